//--- common/fp_mul_pkg.sv
package fp_mul_pkg;

    // Binary32 format constants
    localparam logic [7:0]  exp_bias  = 8'd127;
    localparam logic [7:0]  exp_max   = 8'd255;
    localparam logic [31:0] qnan_word = 32'h7fc00000;

    // Datapath widths
    localparam int frac_w = 23;
    // Fraction plus hidden bit
    localparam int sig_w  = 24;
    // Full significand product
    localparam int prod_w = 48;
    // Leading bit, fraction, guard, round, sticky
    localparam int norm_w = 27;

    // Rounding modes, same encoding as the checker's r_mode
    typedef enum logic [2:0] {
        rne = 3'd0,
        rtz = 3'd1,
        rdn = 3'd2,
        rup = 3'd3,
        rmm = 3'd4
    } rnd_mode_t;

    // Field view of a binary32 word
    typedef struct packed {
        logic              sign;
        logic [7:0]        exp;
        logic [frac_w-1:0] frac;
    } fp32_fields;

    // One word, seen either raw or split into fields
    typedef union packed {
        logic [31:0] raw;
        fp32_fields  fields;
    } fp32_u;

    // Exception flags of one result
    typedef struct packed {
        logic zer;
        logic inf;
        logic nan;
        logic ovrf;
        logic udrf;
    } fp_flags_t;

    // Normaliser output
    // sig[26] leading one, sig[25:3] fraction
    // sig[2] guard, sig[1] round, sig[0] sticky
    typedef struct packed {
        logic              norm_n;
        logic [norm_w-1:0] sig;
    } norm_sig_t;

endpackage

//--- booth/booth_mul.sv
`timescale 1ns/1ps

module booth_mul (
    input  logic [fp_mul_pkg::sig_w-1:0]  a,
    input  logic [fp_mul_pkg::sig_w-1:0]  b,
    output logic [fp_mul_pkg::prod_w-1:0] prod
);

    import fp_mul_pkg::*;

    // Multiplier with an implicit zero below bit 0 and two zeros above
    // Two zeros on top keep b unsigned and give 13 digit groups
    logic [sig_w+2:0] b_ext;

    // Per digit recoding results
    logic [2:0]       grp  [0:sig_w/2];
    logic             neg  [0:sig_w/2];
    logic [sig_w+1:0] mag  [0:sig_w/2];
    logic [prod_w-1:0] pp  [0:sig_w/2];

    // Running sum of partial products
    logic [prod_w-1:0] acc;

    assign b_ext = {2'b00, b, 1'b0};

    // Recode overlapping triplets into digits in -2..+2
    always_comb begin
        for (int i = 0; i <= sig_w/2; i++) begin
            grp[i] = b_ext[2*i +: 3];
            // Upper bit of the triplet gives the sign, except for 111 which is zero
            neg[i] = grp[i][2] && !(grp[i] == 3'b111);
            case (grp[i])
                3'b001, 3'b010, 3'b101, 3'b110: mag[i] = {2'b00, a};
                // Digit of magnitude two, a shifted left once
                3'b011, 3'b100:                 mag[i] = {1'b0, a, 1'b0};
                default:                        mag[i] = '0;
            endcase
        end
    end

    // Signed partial products, weighted by 4^i
    always_comb begin
        for (int i = 0; i <= sig_w/2; i++) begin
            pp[i] = {{(prod_w-sig_w-2){1'b0}}, mag[i]};
            // Two's complement over the full width handles the sign extension
            if (neg[i]) begin
                pp[i] = ~pp[i] + 1'b1;
            end
            pp[i] = pp[i] << (2*i);
        end
    end

    // Sum modulo 2^48; the true product of two 24-bit values always fits
    always_comb begin
        acc = '0;
        for (int i = 0; i <= sig_w/2; i++) begin
            acc = acc + pp[i];
        end
    end

    // A zeroed significand on either side gives all-zero digits or magnitudes
    assign prod = acc;

endmodule

//--- source/fp_norm.sv
`timescale 1ns/1ps

module fp_norm (
    input  logic [fp_mul_pkg::prod_w-1:0] prod,
    output fp_mul_pkg::norm_sig_t         norm
);

    import fp_mul_pkg::*;

    // Product aligned so that its leading one sits at bit 47
    logic [prod_w-1:0] aligned;
    logic              sticky;

    // Product of two values in [1,2) lies in [1,4)
    // Bit 47 set means the product is at least 2 and the exponent grows by one
    assign aligned = prod[prod_w-1] ? prod : {prod[prod_w-2:0], 1'b0};

    // Everything below the round bit collapses into sticky
    assign sticky = |aligned[prod_w-norm_w:0];

    always_comb begin
        norm.norm_n = prod[prod_w-1];
        // Leading bit, fraction, guard and round
        norm.sig[norm_w-1:1] = aligned[prod_w-1 -: norm_w-1];
        norm.sig[0]          = sticky;
    end

endmodule

//--- source/fp_round.sv
`timescale 1ns/1ps

module fp_round (
    input  fp_mul_pkg::norm_sig_t         norm,
    input  logic                          sign,
    input  fp_mul_pkg::rnd_mode_t         r_mode,
    output logic [fp_mul_pkg::frac_w-1:0] frac,
    output logic                          norm_r
);

    import fp_mul_pkg::*;

    // Truncated fraction and the bits below it
    logic [frac_w-1:0] frac_t;
    logic              g;
    logic              rs;
    logic              lsb;
    logic              inc;

    assign frac_t = norm.sig[norm_w-2:3];
    assign g      = norm.sig[2];
    assign rs     = norm.sig[1] | norm.sig[0];
    // LSB decides ties in rne
    assign lsb    = norm.sig[3];

    // Increment decision per mode
    always_comb begin
        case (r_mode)
            // Above half, or exactly half with odd LSB
            rne:     inc = g && (rs || lsb);
            rtz:     inc = 1'b0;
            // Negative results move away from zero when any bit was dropped
            rdn:     inc = sign && (g || rs);
            rup:     inc = !sign && (g || rs);
            // Ties go to larger magnitude
            rmm:     inc = g;
            // Unused encodings truncate
            default: inc = 1'b0;
        endcase
    end

    // Carry out of the fraction means 1.111.. became 10.000..
    // Fraction wraps to zero and the exponent is bumped downstream
    assign {norm_r, frac} = {1'b0, frac_t} + {{frac_w{1'b0}}, inc};

endmodule

//--- source/fp_exp_exc.sv
`timescale 1ns/1ps

module fp_exp_exc (
    input  fp_mul_pkg::fp32_u             x,
    input  fp_mul_pkg::fp32_u             y,
    input  logic [fp_mul_pkg::frac_w-1:0] frac,
    input  logic                          norm_n,
    input  logic                          norm_r,
    output fp_mul_pkg::fp32_u             z,
    output fp_mul_pkg::fp_flags_t         flags
);

    import fp_mul_pkg::*;

    // Operand classes
    logic x_zer, x_inf, x_nan;
    logic y_zer, y_inf, y_nan;

    logic sign;
    // 10-bit sum, negative results show up with bit 9 set
    logic [9:0] exp_sum;
    logic exp_ovf, exp_udf;
    // Both operands are finite and non-zero
    logic ops_normal;
    logic res_nan, res_inf, res_zer;

    // Exponent 0 covers zero and subnormal, both treated as zero
    assign x_zer = (x.fields.exp == 8'd0);
    assign y_zer = (y.fields.exp == 8'd0);
    assign x_inf = (x.fields.exp == exp_max) && (x.fields.frac == '0);
    assign y_inf = (y.fields.exp == exp_max) && (y.fields.frac == '0);
    assign x_nan = (x.fields.exp == exp_max) && (x.fields.frac != '0);
    assign y_nan = (y.fields.exp == exp_max) && (y.fields.frac != '0);

    assign sign = x.fields.sign ^ y.fields.sign;

    // ex + ey - bias, plus one for each of the two normalisation steps
    assign exp_sum = {2'b00, x.fields.exp} + {2'b00, y.fields.exp}
                   + {9'd0, norm_n} + {9'd0, norm_r} - {2'b00, exp_bias};

    // Range of the sum is -127..385, so bit 9 alone marks a negative value
    assign exp_ovf = !exp_sum[9] && (exp_sum >= {2'b00, exp_max});
    assign exp_udf = exp_sum[9] || (exp_sum == 10'd0);

    assign ops_normal = !(x_zer || y_zer || x_inf || y_inf || x_nan || y_nan);

    // Result class, in priority order
    assign res_nan = x_nan || y_nan || (x_inf && y_zer) || (y_inf && x_zer);
    assign res_inf = !res_nan && (x_inf || y_inf || (ops_normal && exp_ovf));
    assign res_zer = !res_nan && !res_inf && (x_zer || y_zer || (ops_normal && exp_udf));

    always_comb begin
        flags.nan  = res_nan;
        flags.inf  = res_inf;
        flags.zer  = res_zer;
        // Range flags only for finite non-zero operands
        flags.ovrf = ops_normal && exp_ovf;
        flags.udrf = ops_normal && exp_udf;

        if (res_nan) begin
            z.raw = qnan_word;
        end else if (res_inf) begin
            z.fields.sign = sign;
            z.fields.exp  = exp_max;
            z.fields.frac = '0;
        end else if (res_zer) begin
            // Flush to signed zero
            z.fields.sign = sign;
            z.fields.exp  = 8'd0;
            z.fields.frac = '0;
        end else begin
            z.fields.sign = sign;
            z.fields.exp  = exp_sum[7:0];
            z.fields.frac = frac;
        end
    end

endmodule

//--- source/fp_mul_top.sv
`timescale 1ns/1ps

module fp_mul_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  fp_mul_pkg::fp32_u     x,
    input  fp_mul_pkg::fp32_u     y,
    input  fp_mul_pkg::rnd_mode_t r_mode,
    output logic                  out_valid,
    output fp_mul_pkg::fp32_u     z,
    output fp_mul_pkg::fp_flags_t flags
);

    import fp_mul_pkg::*;

    // Operand stage
    logic      v_q;
    fp32_u     x_q, y_q;
    rnd_mode_t mode_q;

    // Combinational datapath between the two register stages
    logic [sig_w-1:0]  sig_x, sig_y;
    logic [prod_w-1:0] prod;
    norm_sig_t         norm;
    logic              sign;
    logic [frac_w-1:0] frac;
    logic              norm_r;
    fp32_u             z_d;
    fp_flags_t         flags_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_q <= 1'b0;
        end else begin
            v_q <= in_valid;
        end
    end

    // Operands only move on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            x_q    <= x;
            y_q    <= y;
            mode_q <= r_mode;
        end
    end

    // Hidden bit, with zero and subnormal operands forced to zero
    assign sig_x = (x_q.fields.exp == 8'd0) ? '0 : {1'b1, x_q.fields.frac};
    assign sig_y = (y_q.fields.exp == 8'd0) ? '0 : {1'b1, y_q.fields.frac};
    assign sign  = x_q.fields.sign ^ y_q.fields.sign;

    booth_mul u_booth (.a(sig_x), .b(sig_y), .prod(prod));

    fp_norm u_norm (.prod(prod), .norm(norm));

    fp_round u_round (
        .norm(norm), .sign(sign), .r_mode(mode_q), .frac(frac), .norm_r(norm_r)
    );

    fp_exp_exc u_exp_exc (
        .x(x_q), .y(y_q), .frac(frac), .norm_n(norm.norm_n), .norm_r(norm_r),
        .z(z_d), .flags(flags_d)
    );

    // Result register, one-cycle strobe out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            z         <= '0;
            flags     <= '0;
        end else begin
            out_valid <= v_q;
            if (v_q) begin
                z     <= z_d;
                flags <= flags_d;
            end
        end
    end

endmodule

//--- verif/fp_mul_properties.sv
`timescale 1ns/1ps

module fp_mul_properties (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  in_valid,
    input logic                  out_valid,
    input fp_mul_pkg::fp32_u     z,
    input fp_mul_pkg::fp_flags_t flags
);

    import fp_mul_pkg::*;

    // Result strobe follows the input strobe by two edges, never on its own
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two edges");

    a_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // Every NaN result is the canonical quiet NaN
    a_nan_word: assert property (@(posedge clk) disable iff (!arst_n)
        flags.nan |-> (z.raw == qnan_word))
        else $error("nan flag with a non-canonical result word");

    a_class: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({flags.nan, flags.inf, flags.zer}))
        else $error("more than one result class flag set");

    // Range flags only come with their result class
    a_udrf: assert property (@(posedge clk) disable iff (!arst_n) flags.udrf |-> flags.zer)
        else $error("udrf without zer");

    a_ovrf: assert property (@(posedge clk) disable iff (!arst_n) flags.ovrf |-> flags.inf)
        else $error("ovrf without inf");

endmodule

//--- verif/fp_mul_tb.sv
`timescale 1ns/1ps

module fp_mul_tb;

    import fp_mul_pkg::*;

    localparam int clk_period = 40;
    localparam int n_dir      = 28;
    localparam int n_rand     = 200;
    localparam int n_ops      = n_dir + n_rand;

    // One outstanding operation with its expected result
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  mode;
        logic [31:0] due;
        logic [31:0] z;
        fp_flags_t   flags;
    } expect_t;

    logic      clk;
    logic      arst_n;
    logic      in_valid;
    fp32_u     x, y;
    rnd_mode_t r_mode;
    logic      out_valid;
    fp32_u     z;
    fp_flags_t flags;

    expect_t     exp_q[$];
    logic [31:0] seed = 32'd85;
    int          cyc = 0;
    int          issued = 0;
    int          checked = 0;
    int          err_val = 0;
    int          err_proto = 0;

    fp_mul_top u_dut (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .x(x), .y(y), .r_mode(r_mode),
        .out_valid(out_valid), .z(z), .flags(flags)
    );

    bind fp_mul_top fp_mul_properties u_props (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .out_valid(out_valid),
        .z(z), .flags(flags)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected {z, flags} straight from the binary32 rules
    function automatic logic [36:0] fp_mul_ref(input logic [31:0] a, input logic [31:0] b,
                                               input logic [2:0] mode);
        logic        s;
        int          e;
        logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
        logic [47:0] m;
        logic [24:0] kept;
        logic [23:0] rem;
        logic        up;
        fp_flags_t   f;
        f      = '0;
        s      = a[31] ^ b[31];
        a_zero = (a[30:23] == 8'd0);
        b_zero = (b[30:23] == 8'd0);
        a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
        b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
        a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
        b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
        if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero)) begin
            f.nan = 1'b1;
            return {32'h7fc00000, f};
        end
        if (a_inf || b_inf) begin
            f.inf = 1'b1;
            return {s, 8'hff, 23'd0, f};
        end
        // Subnormals count as zero
        if (a_zero || b_zero) begin
            f.zer = 1'b1;
            return {s, 31'd0, f};
        end
        m = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
        e = int'(a[30:23]) + int'(b[30:23]) - 127;
        // Product in [2,4) bumps the exponent, else align leading one to bit 47
        if (m[47]) begin
            e = e + 1;
        end else begin
            m = m << 1;
        end
        kept = {1'b0, m[47:24]};
        rem  = m[23:0];
        case (mode)
            3'd0:    up = (rem > 24'h800000) || ((rem == 24'h800000) && kept[0]);
            3'd2:    up = s && (rem != 24'd0);
            3'd3:    up = !s && (rem != 24'd0);
            3'd4:    up = (rem >= 24'h800000);
            default: up = 1'b0;
        endcase
        kept = kept + {24'd0, up};
        if (kept[24]) begin
            e    = e + 1;
            kept = kept >> 1;
        end
        if (e >= 255) begin
            f.inf  = 1'b1;
            f.ovrf = 1'b1;
            return {s, 8'hff, 23'd0, f};
        end
        if (e <= 0) begin
            f.zer  = 1'b1;
            f.udrf = 1'b1;
            return {s, 31'd0, f};
        end
        return {s, e[7:0], kept[22:0], f};
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = lcg(seed);
        r    = seed;
    endtask

    // Operand with mid-range exponents most of the time and specials mixed in
    task automatic pick_operand(output logic [31:0] w);
        logic [31:0] r, f;
        logic [7:0]  ex;
        next_rand(r);
        next_rand(f);
        case (r[31:28])
            4'd0:    ex = 8'd0;
            4'd1:    ex = 8'hff;
            4'd2:    ex = 8'hff;
            // Extremes for overflow and underflow
            4'd3:    ex = r[27] ? 8'd190 + {2'b00, r[25:20]} : 8'd1 + {2'b00, r[25:20]};
            default: ex = 8'd96 + {2'b00, r[25:20]};
        endcase
        w = {r[19], ex, f[31:9]};
        if (r[31:28] == 4'd1) begin
            w[22:0] = 23'd0;
        end else if (r[31:28] == 4'd2) begin
            w[0] = 1'b1;
        end else if (r[31:28] == 4'd0 && !r[27]) begin
            w[22:0] = 23'd0;
        end
    endtask

    // Strobe one operation and queue its expected result
    task automatic send(input logic [31:0] a, input logic [31:0] b, input logic [2:0] m);
        expect_t e;
        logic [36:0] res;
        @(posedge clk);
        in_valid <= 1'b1;
        x.raw    <= a;
        y.raw    <= b;
        r_mode   <= rnd_mode_t'(m);
        res = fp_mul_ref(a, b, m);
        e.a     = a;
        e.b     = b;
        e.mode  = m;
        // Strobe seen here, captured next edge, result one edge later, sampled at negedge
        e.due   = cyc + 3;
        e.z     = res[36:5];
        e.flags = res[4:0];
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic run_directed();
        send(32'h40400000, 32'h40400000, 3'd1);
        for (int m = 0; m < 5; m++) begin
            send(32'h3f8ccccd, 32'h3f8ccccd, m[2:0]);
            send(32'hbf8ccccd, 32'h3f8ccccd, m[2:0]);
            send(32'h3fffffff, 32'h3fffffff, m[2:0]);
        end
        // Square root of two squared rounds away from zero up to 2.0 and carries out
        send(32'h3fb504f3, 32'h3fb504f3, 3'd3);
        send(32'hbfb504f3, 32'h3fb504f3, 3'd2);
        // Zeros, subnormal and exponent underflow
        send(32'h00000000, 32'h3f800000, 3'd0);
        send(32'h80000000, 32'h40000000, 3'd0);
        send(32'h00000123, 32'h40400000, 3'd0);
        send(32'h00800000, 32'h00800000, 3'd0);
        // Infinities and exponent overflow
        send(32'h7f800000, 32'h40000000, 3'd0);
        send(32'hff800000, 32'h3f800000, 3'd3);
        send(32'h7f000000, 32'h7f000000, 3'd1);
        // NaN sources
        send(32'h7fc00001, 32'h3f800000, 3'd0);
        send(32'h7f800000, 32'h00000000, 3'd0);
        send(32'h00000001, 32'hff800000, 3'd2);
    endtask

    initial begin
        logic [31:0] a, b, r;
        in_valid = 1'b0;
        x        = '0;
        y        = '0;
        r_mode   = rne;
        arst_n   = 1'b1;
        #5 arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        // Directed set runs back to back
        run_directed();
        for (int g = 0; g < n_rand; g++) begin
            pick_operand(a);
            pick_operand(b);
            next_rand(r);
            send(a, b, 3'(r[27:16] % 5));
            if (r[29:28] == 2'd0) begin
                idle(1);
            end
        end
        idle(1);
        wait (checked == issued);
        // Quiet tail catches any stray out_valid
        idle(4);
        $display("Errors: value %0d, protocol %0d; checked %0d of %0d", err_val, err_proto,
                 checked, issued);
        if (err_val == 0 && err_proto == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Output checker, sampled mid-cycle
    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            cyc = cyc + 1;
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("At %0t out_valid was high with no operation outstanding", $time);
                    err_proto++;
                end else begin
                    e = exp_q.pop_front();
                    checked++;
                    if (cyc != int'(e.due)) begin
                        $display("At %0t a result came in cycle %0d instead of cycle %0d",
                                 $time, cyc, e.due);
                        err_proto++;
                    end
                    if (z.raw !== e.z || flags !== e.flags) begin
                        $display("ERR %0t x=%h y=%h mode=%0d exp z=%h flags=%b got z=%h flags=%b",
                                 $time, e.a, e.b, e.mode, e.z, e.flags, z.raw, flags);
                        err_val++;
                    end
                end
            end
        end
    end

    // Twice the cycles needed for every operation plus reset and tail
    initial begin
        #(clk_period * (n_ops + 20) * 2);
        $display("Timeout: the run did not finish in its time budget, %0d of %0d results seen",
                 checked, issued);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- flist.f
common/fp_mul_pkg.sv
booth/booth_mul.sv
source/fp_norm.sv
source/fp_round.sv
source/fp_exp_exc.sv
source/fp_mul_top.sv
verif/fp_mul_properties.sv
verif/fp_mul_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module fp_mul_tb -o fp_mul_sim &&
./obj_dir/fp_mul_sim | tee /dev/stderr | grep -q "All checks passed" &&
echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }
